/* alloc_pkg.sv */
`default_nettype none

package alloc_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int PTR_WID        = 6;
    localparam int N_BUF          = 2**PTR_WID;
    localparam int BUF_SIZE       = 64;
    localparam int MAX_FRAME_SIZE = 2048;
    localparam int META_WID       = 4;
    localparam int CREDITS        = 4;
    localparam int CNT_WID        = 16;

    typedef logic [PTR_WID-1:0]                  ptr_t;
    typedef logic [$clog2(BUF_SIZE)-1:0]         buf_size_t;
    typedef logic [$clog2(MAX_FRAME_SIZE+1)-1:0] frame_size_t;
    typedef logic [META_WID-1:0]                 meta_t;
    typedef logic [CNT_WID-1:0]                  cnt_t;

    // ========================================
    // Structs
    // ========================================

    // One buffer handed in by the writer
    typedef struct packed {
        logic      eof;
        buf_size_t size;
        meta_t     meta;
        logic      err;
    } store_t;

    // Descriptor as kept in the RAM
    typedef struct packed {
        ptr_t      next;
        logic      eof;
        buf_size_t size;
        meta_t     meta;
        logic      err;
    } desc_t;

    // One gathered buffer going out to the reader
    typedef struct packed {
        ptr_t      ptr;
        logic      eof;
        buf_size_t size;
        meta_t     meta;
        logic      err;
    } load_t;

    typedef struct packed {
        logic  wr;
        ptr_t  addr;
        desc_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_LINK,
        SC_LAST
    } scatter_state_t;

    typedef enum logic [1:0] {
        GA_IDLE,
        GA_READ,
        GA_WAIT,
        GA_SEND
    } gather_state_t;

endpackage

`default_nettype wire

/* alloc_free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_free_list (
    input  logic            clk,
    input  logic            reset,
    input  logic            pop,
    output alloc_pkg::ptr_t pop_ptr,
    output logic            avail,
    input  logic            push,
    input  alloc_pkg::ptr_t push_ptr,
    output logic            init_done,
    output alloc_pkg::cnt_t alloc_cnt,
    output alloc_pkg::cnt_t dealloc_cnt,
    output alloc_pkg::cnt_t active_cnt
);
    import alloc_pkg::*;

    ptr_t             fifo_mem [N_BUF];
    ptr_t             head;
    ptr_t             tail;
    logic [PTR_WID:0] count;
    logic             wr_en;
    ptr_t             wr_data;

    // During init each slot gets its own index
    assign wr_en   = !init_done || push;
    assign wr_data = init_done ? push_ptr : tail;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fifo_mem[tail] <= wr_data;
        end
    end

    assign pop_ptr = fifo_mem[head];
    assign avail   = (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            init_done <= 1'b0;
        end else begin
            if (wr_en) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // Last fill write this cycle
            if (!init_done && tail == ptr_t'(N_BUF-1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // ========================================
    // Statistics
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            alloc_cnt   <= '0;
            dealloc_cnt <= '0;
        end else begin
            if (pop) begin
                alloc_cnt <= alloc_cnt + 1'b1;
            end
            if (push) begin
                dealloc_cnt <= dealloc_cnt + 1'b1;
            end
        end
    end

    assign active_cnt = alloc_cnt - dealloc_cnt;

endmodule

`default_nettype wire

/* alloc_scatter.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_scatter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   init_done,
    input  logic                   store_valid,
    output logic                   store_rdy,
    input  alloc_pkg::store_t      store_in,
    output logic                   pop,
    input  alloc_pkg::ptr_t        pop_ptr,
    input  logic                   avail,
    output logic                   mem_req,
    input  logic                   mem_gnt,
    output alloc_pkg::mem_req_t    mem_cmd,
    output logic                   frame_valid,
    output alloc_pkg::ptr_t        frame_ptr,
    output alloc_pkg::frame_size_t frame_size
);
    import alloc_pkg::*;

    scatter_state_t state;
    logic           have_prev;
    ptr_t           prev_ptr;
    store_t         prev_buf;
    ptr_t           head_ptr;
    frame_size_t    size_acc;
    frame_size_t    buf_bytes;
    ptr_t           wr_addr;
    desc_t          wr_desc;
    logic           accept;

    assign store_rdy = init_done && avail && (state == SC_IDLE);
    assign accept    = store_valid && store_rdy;
    assign pop       = accept;

    // Non-final buffers always count as full
    assign buf_bytes = store_in.eof ? frame_size_t'(store_in.size) : frame_size_t'(BUF_SIZE);

    assign mem_req = (state != SC_IDLE);
    assign mem_cmd = '{wr: 1'b1, addr: wr_addr, wdata: wr_desc};

    assign frame_ptr  = head_ptr;
    assign frame_size = size_acc;

    // ========================================
    // Control
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= SC_IDLE;
            have_prev   <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            case (state)
                SC_IDLE: begin
                    if (accept) begin
                        have_prev <= !store_in.eof;
                        if (have_prev) begin
                            state <= SC_LINK;
                        end else if (store_in.eof) begin
                            state <= SC_LAST;
                        end
                    end
                end
                SC_LINK: begin
                    // prev_buf already holds the new buffer here
                    if (mem_gnt) begin
                        state <= prev_buf.eof ? SC_LAST : SC_IDLE;
                    end
                end
                SC_LAST: begin
                    if (mem_gnt) begin
                        state       <= SC_IDLE;
                        frame_valid <= 1'b1;
                    end
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

    // Held descriptor, write command and frame totals
    always_ff @(posedge clk) begin
        if (accept) begin
            prev_ptr <= pop_ptr;
            prev_buf <= store_in;
            if (have_prev) begin
                wr_addr  <= prev_ptr;
                wr_desc  <= '{next: pop_ptr, eof: prev_buf.eof, size: prev_buf.size,
                              meta: prev_buf.meta, err: prev_buf.err};
                size_acc <= size_acc + buf_bytes;
            end else begin
                head_ptr <= pop_ptr;
                size_acc <= buf_bytes;
                wr_addr  <= pop_ptr;
                wr_desc  <= '{next: '0, eof: store_in.eof, size: store_in.size,
                              meta: store_in.meta, err: store_in.err};
            end
        end else if (state == SC_LINK && mem_gnt) begin
            // Tail descriptor of the frame
            wr_addr <= prev_ptr;
            wr_desc <= '{next: '0, eof: prev_buf.eof, size: prev_buf.size,
                         meta: prev_buf.meta, err: prev_buf.err};
        end
    end

endmodule

`default_nettype wire

/* alloc_gather.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_gather (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_req_valid,
    output logic                load_req_rdy,
    input  alloc_pkg::ptr_t     load_req_ptr,
    output logic                mem_req,
    input  logic                mem_gnt,
    output alloc_pkg::mem_req_t mem_cmd,
    input  logic                rd_valid,
    input  alloc_pkg::desc_t    rd_data,
    output logic                push,
    output alloc_pkg::ptr_t     push_ptr,
    output logic                load_valid,
    output alloc_pkg::load_t    load_out,
    input  logic                load_credit
);
    import alloc_pkg::*;

    typedef logic [$clog2(CREDITS+1)-1:0] credit_t;

    gather_state_t state;
    ptr_t          cur_ptr;
    credit_t       credit;
    logic          req_accept;

    assign req_accept = load_req_valid && load_req_rdy;

    assign mem_req = (state == GA_READ);
    assign mem_cmd = '{wr: 1'b0, addr: cur_ptr, wdata: '0};

    // Buffer goes back to the free list as soon as its descriptor is read
    assign push     = (state == GA_WAIT) && rd_valid;
    assign push_ptr = cur_ptr;

    assign load_valid = (state == GA_SEND) && (credit != '0);

    // ========================================
    // Control
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= GA_IDLE;
            load_req_rdy <= 1'b0;
        end else begin
            case (state)
                GA_IDLE: begin
                    if (req_accept) begin
                        state <= GA_READ;
                    end
                end
                GA_READ: begin
                    if (mem_gnt) begin
                        state <= GA_WAIT;
                    end
                end
                GA_WAIT: begin
                    if (rd_valid) begin
                        state <= GA_SEND;
                    end
                end
                GA_SEND: begin
                    if (load_valid) begin
                        state <= load_out.eof ? GA_IDLE : GA_READ;
                    end
                end
                default: state <= GA_IDLE;
            endcase
            load_req_rdy <= (state == GA_IDLE) && !req_accept;
        end
    end

    // Credit counter
    always_ff @(posedge clk) begin
        if (reset) begin
            credit <= credit_t'(CREDITS);
        end else begin
            case ({load_valid, load_credit})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            cur_ptr <= load_req_ptr;
        end else if (push) begin
            cur_ptr <= rd_data.next;
        end
        if (push) begin
            load_out <= '{ptr: cur_ptr, eof: rd_data.eof, size: rd_data.size,
                          meta: rd_data.meta, err: rd_data.err};
        end
    end

endmodule

`default_nettype wire

/* desc_mem_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_mem_arb (
    input  logic                clk,
    input  logic                reset,
    input  logic                sc_req,
    input  alloc_pkg::mem_req_t sc_cmd,
    output logic                sc_gnt,
    input  logic                ga_req,
    input  alloc_pkg::mem_req_t ga_cmd,
    output logic                ga_gnt,
    output logic                ram_en,
    output alloc_pkg::mem_req_t ram_cmd,
    output logic                rd_valid
);

    // Set when gather had the last grant
    logic last_ga;

    // On a tie the side not granted last wins
    assign sc_gnt = sc_req && (!ga_req || last_ga);
    assign ga_gnt = ga_req && !sc_gnt;

    assign ram_en  = sc_gnt || ga_gnt;
    assign ram_cmd = ga_gnt ? ga_cmd : sc_cmd;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_ga  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (sc_gnt) begin
                last_ga <= 1'b0;
            end else if (ga_gnt) begin
                last_ga <= 1'b1;
            end
            // RAM read data lands one cycle after the grant
            rd_valid <= ram_en && !ram_cmd.wr;
        end
    end

endmodule

`default_nettype wire

/* desc_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_ram (
    input  logic                clk,
    input  logic                en,
    input  alloc_pkg::mem_req_t cmd,
    output alloc_pkg::desc_t    rd_data
);
    import alloc_pkg::*;

    desc_t mem [N_BUF];

    // Single port, so a cycle is either a write or a read
    always_ff @(posedge clk) begin
        if (en) begin
            if (cmd.wr) begin
                mem[cmd.addr] <= cmd.wdata;
            end else begin
                rd_data <= mem[cmd.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* alloc_sg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_sg_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   store_valid,
    output logic                   store_rdy,
    input  alloc_pkg::store_t      store_in,
    output logic                   frame_valid,
    output alloc_pkg::ptr_t        frame_ptr,
    output alloc_pkg::frame_size_t frame_size,
    input  logic                   load_req_valid,
    output logic                   load_req_rdy,
    input  alloc_pkg::ptr_t        load_req_ptr,
    output logic                   load_valid,
    output alloc_pkg::load_t       load_out,
    input  logic                   load_credit,
    output logic                   init_done,
    output alloc_pkg::cnt_t        alloc_cnt,
    output alloc_pkg::cnt_t        dealloc_cnt,
    output alloc_pkg::cnt_t        active_cnt
);
    import alloc_pkg::*;

    logic     pop;
    ptr_t     pop_ptr;
    logic     avail;
    logic     push;
    ptr_t     push_ptr;
    logic     sc_req;
    logic     sc_gnt;
    mem_req_t sc_cmd;
    logic     ga_req;
    logic     ga_gnt;
    mem_req_t ga_cmd;
    logic     ram_en;
    mem_req_t ram_cmd;
    logic     rd_valid;
    desc_t    rd_data;

    alloc_free_list i_free_list (
        .clk         (clk),
        .reset       (reset),
        .pop         (pop),
        .pop_ptr     (pop_ptr),
        .avail       (avail),
        .push        (push),
        .push_ptr    (push_ptr),
        .init_done   (init_done),
        .alloc_cnt   (alloc_cnt),
        .dealloc_cnt (dealloc_cnt),
        .active_cnt  (active_cnt)
    );

    alloc_scatter i_scatter (
        .clk         (clk),
        .reset       (reset),
        .init_done   (init_done),
        .store_valid (store_valid),
        .store_rdy   (store_rdy),
        .store_in    (store_in),
        .pop         (pop),
        .pop_ptr     (pop_ptr),
        .avail       (avail),
        .mem_req     (sc_req),
        .mem_gnt     (sc_gnt),
        .mem_cmd     (sc_cmd),
        .frame_valid (frame_valid),
        .frame_ptr   (frame_ptr),
        .frame_size  (frame_size)
    );

    alloc_gather i_gather (
        .clk            (clk),
        .reset          (reset),
        .load_req_valid (load_req_valid),
        .load_req_rdy   (load_req_rdy),
        .load_req_ptr   (load_req_ptr),
        .mem_req        (ga_req),
        .mem_gnt        (ga_gnt),
        .mem_cmd        (ga_cmd),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .push           (push),
        .push_ptr       (push_ptr),
        .load_valid     (load_valid),
        .load_out       (load_out),
        .load_credit    (load_credit)
    );

    desc_mem_arb i_arb (
        .clk      (clk),
        .reset    (reset),
        .sc_req   (sc_req),
        .sc_cmd   (sc_cmd),
        .sc_gnt   (sc_gnt),
        .ga_req   (ga_req),
        .ga_cmd   (ga_cmd),
        .ga_gnt   (ga_gnt),
        .ram_en   (ram_en),
        .ram_cmd  (ram_cmd),
        .rd_valid (rd_valid)
    );

    desc_ram i_desc_ram (
        .clk     (clk),
        .en      (ram_en),
        .cmd     (ram_cmd),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* alloc_sg_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_sg_asserts (
    input logic clk,
    input logic reset,
    input logic load_valid,
    input logic load_credit,
    input logic store_rdy,
    input logic init_done,
    input logic frame_valid
);
    import alloc_pkg::*;

    // Credits seen from the outside of the gather engine
    int credit;
    int fail_cnt = 0;

    always @(posedge clk) begin
        if (reset) begin
            credit <= CREDITS;
        end else begin
            credit <= credit - int'(load_valid) + int'(load_credit);
        end
    end

    a_credit: assert property (@(posedge clk) disable iff (reset) load_valid |-> credit > 0)
        else begin
            fail_cnt++;
            $error("load_valid with no credit left");
        end

    a_rdy_init: assert property (@(posedge clk) disable iff (reset) !init_done |-> !store_rdy)
        else begin
            fail_cnt++;
            $error("store_rdy high before init_done");
        end

    a_frame_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_valid |=> !frame_valid)
        else begin
            fail_cnt++;
            $error("frame_valid longer than one cycle");
        end

endmodule

bind alloc_sg_top alloc_sg_asserts i_asserts (
    .clk         (clk),
    .reset       (reset),
    .load_valid  (load_valid),
    .load_credit (load_credit),
    .store_rdy   (store_rdy),
    .init_done   (init_done),
    .frame_valid (frame_valid)
);

`default_nettype wire

/* alloc_sg_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_sg_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   store_valid,
    input  logic                   store_rdy,
    input  alloc_pkg::store_t      store_in,
    input  logic                   frame_valid,
    input  alloc_pkg::ptr_t        frame_ptr,
    input  alloc_pkg::frame_size_t frame_size,
    input  logic                   load_req_rdy,
    input  logic                   load_valid,
    input  alloc_pkg::load_t       load_out,
    input  logic                   load_credit,
    input  logic                   init_done,
    input  alloc_pkg::cnt_t        alloc_cnt,
    input  alloc_pkg::cnt_t        dealloc_cnt,
    input  alloc_pkg::cnt_t        active_cnt,
    input  logic [3:0]             test_id,
    input  logic                   test_end,
    input  logic                   check_now,
    output int                     error_cnt
);
    import alloc_pkg::*;

    typedef struct packed {
        ptr_t        ptr;
        frame_size_t size;
    } report_t;

    // ========================================
    // Model state
    // ========================================
    ptr_t        free_q[$];
    load_t       beat_q[$];
    report_t     report_q[$];
    logic        frame_open;
    ptr_t        cur_head;
    int          cur_full;
    int          credit;
    int          alloc_model;
    int          dealloc_model;
    int          init_cycles;
    logic        init_seen;
    logic        reset_q;
    int          test_errs;

    initial begin
        error_cnt     = 0;
        test_errs     = 0;
        alloc_model   = 0;
        dealloc_model = 0;
        frame_open    = 1'b0;
        init_seen     = 1'b0;
        reset_q       = 1'b0;
        for (int i = 0; i < N_BUF; i++) begin
            free_q.push_back(ptr_t'(i));
        end
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    test_name = "initialization";
            4'd2:    test_name = "single-buffer frame";
            4'd3:    test_name = "multi-buffer frames";
            4'd4:    test_name = "counters";
            4'd5:    test_name = "credit back-pressure";
            4'd6:    test_name = "pointer recycling";
            default: test_name = "unknown";
        endcase
    endfunction

    task automatic mismatch(input string what, input int got, input int exp);
        $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        error_cnt++;
        test_errs++;
    endtask

    task automatic flag(input string what);
        $display("Error at %0t: %s", $time, what);
        error_cnt++;
        test_errs++;
    endtask

    always @(posedge clk) begin
        report_t rep;
        load_t   exp;
        ptr_t    p;
        if (reset) begin
            credit      = CREDITS;
            init_cycles = 0;
            if (reset_q && (store_rdy || frame_valid || load_valid || load_req_rdy || init_done)) begin
                flag("an output that should be low is high during reset");
            end
        end else begin
            if (!init_done) begin
                init_cycles++;
            end else if (!init_seen) begin
                init_seen = 1'b1;
                if (init_cycles != N_BUF) begin
                    mismatch("init cycles", init_cycles, N_BUF);
                end
            end
            // Counters before this edge's updates
            if (check_now || test_end) begin
                if (alloc_cnt != cnt_t'(alloc_model)) begin
                    mismatch("alloc_cnt", alloc_cnt, alloc_model);
                end
                if (dealloc_cnt != cnt_t'(dealloc_model)) begin
                    mismatch("dealloc_cnt", dealloc_cnt, dealloc_model);
                end
                if (active_cnt != cnt_t'(alloc_model - dealloc_model)) begin
                    mismatch("active_cnt", active_cnt, alloc_model - dealloc_model);
                end
            end
            if (store_valid && store_rdy) begin
                if (free_q.size() == 0) begin
                    flag("a buffer was accepted while the model free list is empty");
                end else begin
                    p = free_q.pop_front();
                    alloc_model++;
                    if (!frame_open) begin
                        cur_head = p;
                        cur_full = 0;
                    end
                    beat_q.push_back('{ptr: p, eof: store_in.eof, size: store_in.size,
                                       meta: store_in.meta, err: store_in.err});
                    // Full buffers times the buffer size, plus the bytes of the last one
                    if (store_in.eof) begin
                        report_q.push_back('{ptr: cur_head,
                                             size: frame_size_t'(cur_full * BUF_SIZE
                                                                 + int'(store_in.size))});
                    end else begin
                        cur_full++;
                    end
                    frame_open = !store_in.eof;
                end
            end
            if (frame_valid) begin
                if (report_q.size() == 0) begin
                    flag("frame reported with no frame finished");
                end else begin
                    rep = report_q.pop_front();
                    if (frame_ptr != rep.ptr) begin
                        mismatch("frame_ptr", frame_ptr, rep.ptr);
                    end
                    if (frame_size != rep.size) begin
                        mismatch("frame_size", frame_size, rep.size);
                    end
                end
            end
            if (load_valid) begin
                if (credit <= 0) begin
                    flag("a beat was delivered with no credit left");
                end
                credit--;
                if (beat_q.size() == 0) begin
                    flag("a beat was delivered that was never stored");
                end else begin
                    exp = beat_q.pop_front();
                    if (load_out !== exp) begin
                        $display("FAIL %0t: beat ptr %0d eof %0b size %0d meta %0d err %0b, %s",
                                 $time, load_out.ptr, load_out.eof, load_out.size,
                                 load_out.meta, load_out.err, "does not match the model");
                        $display("    expected ptr %0d eof %0b size %0d meta %0d err %0b",
                                 exp.ptr, exp.eof, exp.size, exp.meta, exp.err);
                        error_cnt++;
                        test_errs++;
                    end
                    free_q.push_back(exp.ptr);
                    dealloc_model++;
                end
            end
            if (load_credit) begin
                credit++;
            end
            if (test_end) begin
                $display("Test %0d %s: %s, %0d errors", test_id, test_name(test_id),
                         (test_errs == 0) ? "passed" : "failed", test_errs);
                test_errs = 0;
            end
        end
        reset_q = reset;
    end

endmodule

`default_nettype wire

/* alloc_sg_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_sg_tb;
    import alloc_pkg::*;

    localparam int N_FRAMES    = 11;
    localparam int WATCHDOG_NS = (N_FRAMES * 200 + N_BUF + 20) * 8;
    localparam int WAIT_LIMIT  = 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic        store_valid;
    logic        store_rdy;
    store_t      store_in;
    logic        frame_valid;
    ptr_t        frame_ptr;
    frame_size_t frame_size;
    logic        load_req_valid;
    logic        load_req_rdy;
    ptr_t        load_req_ptr;
    logic        load_valid;
    load_t       load_out;
    logic        load_credit;
    logic        init_done;
    cnt_t        alloc_cnt;
    cnt_t        dealloc_cnt;
    cnt_t        active_cnt;
    logic [3:0]  test_id;
    logic        test_end;
    logic        check_now;
    logic        hold_credits;
    int          check_errs;
    int          tb_errs     = 0;
    int          seed        = 32'hc3a4_da63;
    int          beats_total = 0;
    int          credits_ret = 0;
    int          frames_seen = 0;
    int          gap;
    ptr_t        heads[$];
    int          pend_lens[$];

    always #4 clk = ~clk;

    alloc_sg_top i_alloc_sg_top (.*);

    alloc_sg_checker i_checker (
        .clk (clk), .reset (reset), .store_valid (store_valid), .store_rdy (store_rdy),
        .store_in (store_in), .frame_valid (frame_valid), .frame_ptr (frame_ptr),
        .frame_size (frame_size), .load_req_rdy (load_req_rdy), .load_valid (load_valid),
        .load_out (load_out), .load_credit (load_credit), .init_done (init_done),
        .alloc_cnt (alloc_cnt), .dealloc_cnt (dealloc_cnt), .active_cnt (active_cnt),
        .test_id (test_id), .test_end (test_end), .check_now (check_now),
        .error_cnt (check_errs)
    );

    function automatic int rand_range(input int lo, input int hi);
        rand_range = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Beats and frame heads seen on the DUT outputs
    always @(posedge clk) begin
        if (!reset) begin
            if (load_valid) begin
                beats_total <= beats_total + 1;
            end
            if (frame_valid) begin
                heads.push_back(frame_ptr);
                frames_seen <= frames_seen + 1;
            end
        end
    end

    // Credit return with random gaps
    initial begin
        load_credit = 1'b0;
        gap         = 0;
        forever begin
            @(posedge clk);
            #1;
            load_credit = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (!hold_credits && beats_total > credits_ret) begin
                load_credit = 1'b1;
                credits_ret++;
                #1;
                gap = rand_range(0, 3);
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        tb_errs++;
    endtask

    task automatic store_frame(input int len);
        int   n_buf;
        int   cnt;
        int   target;
        meta_t meta;
        n_buf  = len / BUF_SIZE + 1;
        target = frames_seen + 1;
        meta   = meta_t'(rand_range(0, 15));
        for (int i = 0; i < n_buf; i++) begin
            store_in    = '{eof: (i == n_buf - 1), size: buf_size_t'(len % BUF_SIZE),
                            meta: meta, err: 1'b0};
            store_valid = 1'b1;
            cnt = 0;
            while (!store_rdy && cnt < WAIT_LIMIT) begin
                next_cycle();
                cnt++;
            end
            next_cycle();
            store_valid = 1'b0;
        end
        cnt = 0;
        while (frames_seen < target && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            timeout("the DUT did not report a stored frame");
        end
        pend_lens.push_back(len);
    endtask

    task automatic request_load(input ptr_t ptr);
        int cnt;
        load_req_ptr   = ptr;
        load_req_valid = 1'b1;
        cnt = 0;
        while (!load_req_rdy && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
        end
        next_cycle();
        load_req_valid = 1'b0;
    endtask

    task automatic wait_beats(input int target, input logic settle);
        int cnt;
        cnt = 0;
        while ((beats_total < target || (settle && credits_ret < beats_total))
               && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            timeout("the DUT did not deliver the expected beats");
        end
    endtask

    task automatic load_pending();
        int len;
        while (pend_lens.size() > 0) begin
            len = pend_lens.pop_front();
            if (heads.size() == 0) begin
                timeout("no frame head is left to load");
            end else begin
                request_load(heads.pop_front());
                wait_beats(beats_total + len / BUF_SIZE + 1, 1'b1);
            end
        end
    endtask

    task automatic pulse(input logic is_end);
        if (is_end) begin
            test_end = 1'b1;
        end else begin
            check_now = 1'b1;
        end
        next_cycle();
        test_end  = 1'b0;
        check_now = 1'b0;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int cnt;
        int start;
        reset          = 1'b1;
        store_valid    = 1'b0;
        store_in       = '0;
        load_req_valid = 1'b0;
        load_req_ptr   = '0;
        test_id        = '0;
        test_end       = 1'b0;
        check_now      = 1'b0;
        hold_credits   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_id = 4'd1;
        cnt = 0;
        while (!init_done && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            timeout("init_done never rose");
        end
        pulse(1'b1);

        test_id = 4'd2;
        store_frame(rand_range(1, BUF_SIZE - 1));
        load_pending();
        pulse(1'b1);

        test_id = 4'd3;
        for (int i = 0; i < 3; i++) begin
            store_frame(rand_range(BUF_SIZE + 1, 1000));
        end
        load_pending();
        pulse(1'b1);

        test_id = 4'd4;
        for (int i = 0; i < 4; i++) begin
            store_frame(rand_range(1, 700));
        end
        pulse(1'b0);
        load_pending();
        pulse(1'b1);

        test_id = 4'd5;
        store_frame(700);
        void'(pend_lens.pop_front());
        start        = beats_total;
        hold_credits = 1'b1;
        request_load(heads.pop_front());
        wait_beats(start + CREDITS, 1'b0);
        repeat (20) next_cycle();
        hold_credits = 1'b0;
        wait_beats(start + 700 / BUF_SIZE + 1, 1'b1);
        pulse(1'b1);

        test_id = 4'd6;
        store_frame(rand_range(1, MAX_FRAME_SIZE - 1));
        store_frame(rand_range(1, MAX_FRAME_SIZE - 1));
        load_pending();
        pulse(1'b1);

        repeat (4) next_cycle();
        cnt = check_errs + tb_errs + i_alloc_sg_top.i_asserts.fail_cnt;
        $display("Tests run: 6, errors: %0d", cnt);
        if (cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
alloc_pkg.sv
alloc_free_list.sv
alloc_scatter.sv
alloc_gather.sv
desc_mem_arb.sv
desc_ram.sv
alloc_sg_top.sv
alloc_sg_asserts.sv
alloc_sg_checker.sv
alloc_sg_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module alloc_sg_tb -o alloc_sg_sim
	./obj_dir/alloc_sg_sim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
